//--- design/sd_card_pkg.sv
/*
 Shared widths, command indices and card constants for the SD card model.
 Replies are 120-bit payloads. Short replies use only the low 32 bits.
 The CID product-name field is 40 bits wide, so it keeps only "MODEL".
*/
package sd_card_pkg;

	// Word and field widths
	localparam int SD_WORD_W    = 32;
	localparam int CMD_IDX_W    = 6;
	localparam int REPLY_ARG_W  = 120;
	localparam int BLOCK_WORDS  = 128;
	localparam int BLOCK_ADDR_W = 7;

	// Command indices
	localparam logic [CMD_IDX_W-1:0] CMD_GO_IDLE        = 6'd0;
	localparam logic [CMD_IDX_W-1:0] CMD_ALL_SEND_CID   = 6'd2;
	localparam logic [CMD_IDX_W-1:0] CMD_SEND_RCA       = 6'd3;
	localparam logic [CMD_IDX_W-1:0] CMD_SELECT         = 6'd7;
	localparam logic [CMD_IDX_W-1:0] CMD_SEND_IF_COND   = 6'd8;
	localparam logic [CMD_IDX_W-1:0] CMD_READ_SINGLE    = 6'd17;
	localparam logic [CMD_IDX_W-1:0] CMD_WRITE_SINGLE   = 6'd24;
	localparam logic [CMD_IDX_W-1:0] CMD_APP            = 6'd55;
	localparam logic [CMD_IDX_W-1:0] ACMD_SEND_OP_COND  = 6'd41;

	// Supported voltage window, lands on OCR bits 23..8
	localparam logic [15:0] OCR_WINDOW = 16'hff80;

	// R1 status bits
	localparam int R1_READY_BIT = 8;
	localparam int R1_APP_BIT   = 5;

	// Maker, app ID, name, revision, serial, reserved, date code
	localparam logic [63:0] CID_NAME = "SM-MODEL";
	localparam logic [REPLY_ARG_W-1:0] CARD_CID = {8'h47, 16'h4754, CID_NAME[39:0],
		8'h10, 32'h1234_5678, 4'h0, 12'h1a5};

endpackage

//--- design/sd_word_ram.sv
/*
 Word RAM with one write port and one registered read port.
 Read data appears one cycle after the address. No reset, contents start unknown.
*/
`timescale 1ns/1ns
module sd_word_ram import sd_card_pkg::*; #(
	parameter int ADDR_W = 7
) (
	input  logic                 sd_clk,
	input  logic                 i_we,
	input  logic [ADDR_W-1:0]    i_waddr,
	input  logic [SD_WORD_W-1:0] i_wdata,
	input  logic [ADDR_W-1:0]    i_raddr,
	output logic [SD_WORD_W-1:0] o_rdata
);

	logic [SD_WORD_W-1:0] mem [0:(1<<ADDR_W)-1];

	// Write port
	always_ff @(posedge sd_clk)
		if (i_we)
			mem[i_waddr] <= i_wdata;

	// Registered read, old data on a same-address collision
	always_ff @(posedge sd_clk)
		o_rdata <= mem[i_raddr];

endmodule

//--- design/sd_cmd_fsm.sv
/*
 Card command state machine: identification, selection, replies, block requests.
 One reply at a time. The host must not send while a reply is pending.
 POWER_UP_POLLS must be at least 1 and CARD_RCA must be nonzero.
*/
`timescale 1ns/1ns
module sd_cmd_fsm import sd_card_pkg::*; #(
	parameter logic [15:0] CARD_RCA          = 16'h5a3c,
	parameter int          POWER_UP_POLLS    = 2,
	parameter bit          OPT_HIGH_CAPACITY = 1'b1,
	parameter int          LG_MEM_BLOCKS     = 4
) (
	input  logic                     sd_clk,
	input  logic                     i_rst_n,
	input  logic                     i_cmd_valid,
	input  logic [CMD_IDX_W-1:0]     i_cmd_idx,
	input  logic [SD_WORD_W-1:0]     i_cmd_arg,
	input  logic                     i_reply_ready,
	input  logic                     i_eng_busy,
	output logic                     o_reply_valid,
	output logic [CMD_IDX_W-1:0]     o_reply_idx,
	output logic                     o_reply_long,
	output logic [REPLY_ARG_W-1:0]   o_reply_arg,
	output logic                     o_blk_req_valid,
	output logic                     o_blk_req_write,
	output logic [LG_MEM_BLOCKS-1:0] o_blk_req_addr
);

	localparam int POLL_W = $clog2(POWER_UP_POLLS + 1);

	// Card state
	logic              app_cmd;
	logic              cmd8_sent;
	logic [POLL_W-1:0] poll_cnt;
	logic              ready;
	logic              hcs;
	logic [15:0]       rca;
	logic              selected;

	// Decode of the incoming command
	logic                   go_idle;
	logic [POLL_W:0]        poll_num;
	logic                   poll_done;
	logic                   ocr_ok;
	logic                   hcs_nxt;
	logic                   rca_match;
	logic [SD_WORD_W-1:0]   r1;
	logic [SD_WORD_W-1:0]   blk_num;
	logic                   reply_go;
	logic                   req_go;
	logic [CMD_IDX_W-1:0]   nxt_idx;
	logic                   nxt_long;
	logic [REPLY_ARG_W-1:0] nxt_arg;

	assign go_idle   = i_cmd_valid && (i_cmd_idx == CMD_GO_IDLE);
	assign poll_num  = {1'b0, poll_cnt} + 1'b1;
	assign poll_done = ready || (poll_num >= POWER_UP_POLLS);
	assign ocr_ok    = |(i_cmd_arg[23:8] & OCR_WINDOW);
	assign hcs_nxt   = OPT_HIGH_CAPACITY && cmd8_sent && i_cmd_arg[30];
	// RCA of zero means not yet addressed
	assign rca_match = (rca != 16'h0) && (i_cmd_arg[31:16] == rca);
	// Byte addressing drops the 512-byte offset
	assign blk_num   = hcs ? i_cmd_arg : (i_cmd_arg >> 9);

	//////////////////////////////////////////////////
	// Reply and request decision
	always_comb
	begin
		r1 = '0;
		r1[R1_READY_BIT] = !i_eng_busy;
		reply_go = 1'b0;
		req_go   = 1'b0;
		nxt_idx  = i_cmd_idx;
		nxt_long = 1'b0;
		nxt_arg  = '0;
		case (i_cmd_idx)
		CMD_SEND_IF_COND:
		begin
			reply_go = 1'b1;
			nxt_arg[31:0] = i_cmd_arg;
		end
		CMD_APP:
		begin
			reply_go = 1'b1;
			nxt_arg[31:0] = r1;
			nxt_arg[R1_APP_BIT] = 1'b1;
		end
		ACMD_SEND_OP_COND:
			if (app_cmd)
			begin
				// OCR reply carries the R3 index of all ones
				reply_go = 1'b1;
				nxt_idx  = '1;
				nxt_arg[31]   = ocr_ok && poll_done;
				nxt_arg[30]   = hcs_nxt;
				nxt_arg[23:8] = OCR_WINDOW;
			end
		CMD_ALL_SEND_CID:
			if (ready && (rca == 16'h0))
			begin
				reply_go = 1'b1;
				nxt_idx  = '1;
				nxt_long = 1'b1;
				nxt_arg  = CARD_CID;
			end
		CMD_SEND_RCA:
			if (ready)
			begin
				reply_go = 1'b1;
				nxt_arg[31:16] = CARD_RCA;
			end
		CMD_SELECT:
			if (rca_match)
			begin
				reply_go = 1'b1;
				nxt_arg[31:0] = r1;
			end
		CMD_READ_SINGLE, CMD_WRITE_SINGLE:
			if (selected && !i_eng_busy)
			begin
				reply_go = 1'b1;
				req_go   = 1'b1;
				nxt_arg[31:0] = r1;
			end
		default:
			reply_go = 1'b0;
		endcase
		reply_go = reply_go && i_cmd_valid;
		req_go   = req_go && i_cmd_valid;
	end

	//////////////////////////////////////////////////
	// Card state, cleared by reset or CMD0
	always_ff @(posedge sd_clk)
		if (!i_rst_n || go_idle)
		begin
			app_cmd   <= 1'b0;
			cmd8_sent <= 1'b0;
			poll_cnt  <= '0;
			ready     <= 1'b0;
			hcs       <= 1'b0;
			rca       <= 16'h0;
			selected  <= 1'b0;
		end
		else if (i_cmd_valid)
		begin
			// App flag lasts for exactly one command
			app_cmd <= (i_cmd_idx == CMD_APP);
			case (i_cmd_idx)
			CMD_SEND_IF_COND:
				cmd8_sent <= 1'b1;
			ACMD_SEND_OP_COND:
				if (app_cmd)
				begin
					hcs <= hcs_nxt;
					if (!ocr_ok)
						ready <= 1'b0;
					else if (poll_done)
						ready <= 1'b1;
					else
						poll_cnt <= poll_num[POLL_W-1:0];
				end
			CMD_SEND_RCA:
				if (ready)
					rca <= CARD_RCA;
			CMD_SELECT:
				selected <= rca_match;
			default:
				selected <= selected;
			endcase
		end

	// Reply held until accepted, request is a single pulse
	always_ff @(posedge sd_clk)
		if (!i_rst_n)
		begin
			o_reply_valid   <= 1'b0;
			o_blk_req_valid <= 1'b0;
		end
		else
		begin
			o_blk_req_valid <= req_go;
			if (reply_go)
				o_reply_valid <= 1'b1;
			else if (i_reply_ready)
				o_reply_valid <= 1'b0;
		end

	// Reply and request payload
	always_ff @(posedge sd_clk)
	begin
		if (reply_go)
		begin
			o_reply_idx  <= nxt_idx;
			o_reply_long <= nxt_long;
			o_reply_arg  <= nxt_arg;
		end
		if (req_go)
		begin
			o_blk_req_write <= (i_cmd_idx == CMD_WRITE_SINGLE);
			o_blk_req_addr  <= blk_num[LG_MEM_BLOCKS-1:0];
		end
	end

endmodule

//--- design/sd_data_engine.sv
/*
 Block data engine between the host ports, the block buffer and the block store.
 Takes one request at a time. Both RAMs have one-cycle read latency.
 Write data is unthrottled, read data uses valid/ready.
*/
`timescale 1ns/1ns
module sd_data_engine import sd_card_pkg::*; #(
	parameter int LG_MEM_BLOCKS = 4
) (
	input  logic                                  sd_clk,
	input  logic                                  i_rst_n,
	input  logic                                  i_blk_req_valid,
	input  logic                                  i_blk_req_write,
	input  logic [LG_MEM_BLOCKS-1:0]              i_blk_req_addr,
	input  logic                                  i_rx_valid,
	input  logic [SD_WORD_W-1:0]                  i_rx_data,
	input  logic                                  i_tx_ready,
	output logic                                  o_eng_busy,
	output logic                                  o_tx_valid,
	output logic [SD_WORD_W-1:0]                  o_tx_data,
	output logic                                  o_tx_last,
	output logic                                  o_card_busy,
	// Block buffer
	output logic                                  o_buf_we,
	output logic [BLOCK_ADDR_W-1:0]               o_buf_waddr,
	output logic [SD_WORD_W-1:0]                  o_buf_wdata,
	output logic [BLOCK_ADDR_W-1:0]               o_buf_raddr,
	input  logic [SD_WORD_W-1:0]                  i_buf_rdata,
	// Block store
	output logic                                  o_store_we,
	output logic [LG_MEM_BLOCKS+BLOCK_ADDR_W-1:0] o_store_waddr,
	output logic [SD_WORD_W-1:0]                  o_store_wdata,
	output logic [LG_MEM_BLOCKS+BLOCK_ADDR_W-1:0] o_store_raddr,
	input  logic [SD_WORD_W-1:0]                  i_store_rdata
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RECV,
		S_WCOPY,
		S_RCOPY,
		S_STREAM
	} state_t;

	state_t                   state;
	// One extra bit so copies can run 0..BLOCK_WORDS
	logic [BLOCK_ADDR_W:0]    cnt;
	logic [BLOCK_ADDR_W-1:0]  cnt_lo;
	logic [BLOCK_ADDR_W-1:0]  cnt_prev;
	logic [BLOCK_ADDR_W-1:0]  rd_next;
	logic                     cnt_end;
	logic [LG_MEM_BLOCKS-1:0] blk;

	assign cnt_lo   = cnt[BLOCK_ADDR_W-1:0];
	// Copy writes trail reads by the RAM latency
	assign cnt_prev = cnt_lo - 1'b1;
	assign rd_next  = cnt_lo + 1'b1;
	assign cnt_end  = (cnt == (BLOCK_ADDR_W+1)'(BLOCK_WORDS));

	// Status and stream outputs decoded from state
	assign o_eng_busy  = (state != S_IDLE);
	assign o_card_busy = (state == S_WCOPY);
	assign o_tx_valid  = (state == S_STREAM);
	assign o_tx_last   = o_tx_valid && (&cnt_lo);
	// Buffer output register is the prefetch stage
	assign o_tx_data   = i_buf_rdata;

	assign o_store_waddr = {blk, cnt_prev};
	assign o_store_raddr = {blk, cnt_lo};
	assign o_store_wdata = i_buf_rdata;

	//////////////////////////////////////////////////
	// RAM port control
	always_comb
	begin
		o_buf_we    = 1'b0;
		o_buf_waddr = cnt_lo;
		o_buf_wdata = i_rx_data;
		o_buf_raddr = cnt_lo;
		o_store_we  = 1'b0;
		case (state)
		S_RECV:
			o_buf_we = i_rx_valid;
		S_WCOPY:
			o_store_we = (cnt != '0);
		S_RCOPY:
		begin
			o_buf_we    = (cnt != '0);
			o_buf_waddr = cnt_prev;
			o_buf_wdata = i_store_rdata;
			// Word 0 is read ahead so streaming starts on time
			o_buf_raddr = '0;
		end
		S_STREAM:
			// Hold the address on a stall so data stays put
			if (i_tx_ready)
				o_buf_raddr = rd_next;
		default:
			o_buf_we = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////
	// Transfer sequencing
	always_ff @(posedge sd_clk)
		if (!i_rst_n)
		begin
			state <= S_IDLE;
			cnt   <= '0;
		end
		else
		begin
			case (state)
			S_IDLE:
				if (i_blk_req_valid)
				begin
					state <= i_blk_req_write ? S_RECV : S_RCOPY;
					cnt   <= '0;
				end
			S_RECV:
				if (i_rx_valid)
				begin
					cnt <= cnt + 1'b1;
					// Last word of the block
					if (&cnt_lo)
					begin
						state <= S_WCOPY;
						cnt   <= '0;
					end
				end
			S_WCOPY, S_RCOPY:
				if (cnt_end)
				begin
					state <= (state == S_WCOPY) ? S_IDLE : S_STREAM;
					cnt   <= '0;
				end
				else
					cnt <= cnt + 1'b1;
			S_STREAM:
				if (i_tx_ready)
				begin
					cnt <= cnt + 1'b1;
					if (o_tx_last)
						state <= S_IDLE;
				end
			default:
				state <= S_IDLE;
			endcase
		end

	// Block number for the current transfer
	always_ff @(posedge sd_clk)
		if (i_blk_req_valid && (state == S_IDLE))
			blk <= i_blk_req_addr;

endmodule

//--- design/sd_card_top.sv
/*
 SD card model top: command FSM, data engine, block buffer and block store.
 Store holds 2**LG_MEM_BLOCKS blocks, block numbers wrap modulo that size.
*/
`timescale 1ns/1ns
module sd_card_top import sd_card_pkg::*; #(
	parameter logic [15:0] CARD_RCA          = 16'h5a3c,
	parameter int          POWER_UP_POLLS    = 2,
	parameter bit          OPT_HIGH_CAPACITY = 1'b1,
	parameter int          LG_MEM_BLOCKS     = 4
) (
	input  logic                   sd_clk,
	input  logic                   i_rst_n,
	input  logic                   i_cmd_valid,
	input  logic [CMD_IDX_W-1:0]   i_cmd_idx,
	input  logic [SD_WORD_W-1:0]   i_cmd_arg,
	input  logic                   i_reply_ready,
	input  logic                   i_rx_valid,
	input  logic [SD_WORD_W-1:0]   i_rx_data,
	input  logic                   i_tx_ready,
	output logic                   o_reply_valid,
	output logic [CMD_IDX_W-1:0]   o_reply_idx,
	output logic                   o_reply_long,
	output logic [REPLY_ARG_W-1:0] o_reply_arg,
	output logic                   o_tx_valid,
	output logic [SD_WORD_W-1:0]   o_tx_data,
	output logic                   o_tx_last,
	output logic                   o_card_busy
);

	localparam int STORE_AW = LG_MEM_BLOCKS + BLOCK_ADDR_W;

	// FSM to engine
	logic                     blk_req_valid;
	logic                     blk_req_write;
	logic [LG_MEM_BLOCKS-1:0] blk_req_addr;
	logic                     eng_busy;

	// RAM ports
	logic                     buf_we;
	logic [BLOCK_ADDR_W-1:0]  buf_waddr;
	logic [SD_WORD_W-1:0]     buf_wdata;
	logic [BLOCK_ADDR_W-1:0]  buf_raddr;
	logic [SD_WORD_W-1:0]     buf_rdata;
	logic                     store_we;
	logic [STORE_AW-1:0]      store_waddr;
	logic [SD_WORD_W-1:0]     store_wdata;
	logic [STORE_AW-1:0]      store_raddr;
	logic [SD_WORD_W-1:0]     store_rdata;

	sd_cmd_fsm #(
		.CARD_RCA(CARD_RCA), .POWER_UP_POLLS(POWER_UP_POLLS),
		.OPT_HIGH_CAPACITY(OPT_HIGH_CAPACITY), .LG_MEM_BLOCKS(LG_MEM_BLOCKS)
	) sd_cmd_fsm_inst (
		.sd_clk(sd_clk), .i_rst_n(i_rst_n),
		.i_cmd_valid(i_cmd_valid), .i_cmd_idx(i_cmd_idx), .i_cmd_arg(i_cmd_arg),
		.i_reply_ready(i_reply_ready), .i_eng_busy(eng_busy),
		.o_reply_valid(o_reply_valid), .o_reply_idx(o_reply_idx),
		.o_reply_long(o_reply_long), .o_reply_arg(o_reply_arg),
		.o_blk_req_valid(blk_req_valid), .o_blk_req_write(blk_req_write),
		.o_blk_req_addr(blk_req_addr)
	);

	sd_data_engine #(
		.LG_MEM_BLOCKS(LG_MEM_BLOCKS)
	) sd_data_engine_inst (
		.sd_clk(sd_clk), .i_rst_n(i_rst_n),
		.i_blk_req_valid(blk_req_valid), .i_blk_req_write(blk_req_write),
		.i_blk_req_addr(blk_req_addr),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .i_tx_ready(i_tx_ready),
		.o_eng_busy(eng_busy), .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data),
		.o_tx_last(o_tx_last), .o_card_busy(o_card_busy),
		.o_buf_we(buf_we), .o_buf_waddr(buf_waddr), .o_buf_wdata(buf_wdata),
		.o_buf_raddr(buf_raddr), .i_buf_rdata(buf_rdata),
		.o_store_we(store_we), .o_store_waddr(store_waddr),
		.o_store_wdata(store_wdata), .o_store_raddr(store_raddr),
		.i_store_rdata(store_rdata)
	);

	// One block staging buffer
	sd_word_ram #(
		.ADDR_W(BLOCK_ADDR_W)
	) buf_ram_inst (
		.sd_clk(sd_clk), .i_we(buf_we), .i_waddr(buf_waddr), .i_wdata(buf_wdata),
		.i_raddr(buf_raddr), .o_rdata(buf_rdata)
	);

	// Card block store
	sd_word_ram #(
		.ADDR_W(STORE_AW)
	) store_ram_inst (
		.sd_clk(sd_clk), .i_we(store_we), .i_waddr(store_waddr),
		.i_wdata(store_wdata), .i_raddr(store_raddr), .o_rdata(store_rdata)
	);

endmodule

//--- testbench/tb_clock_gen.sv
/*
 Clock and reset source for the testbench.
 Reset is released with a non-blocking update on a rising edge.
*/
`timescale 1ns/1ns
module tb_clock_gen #(
	parameter int PERIOD_NS  = 20,
	parameter int RST_CYCLES = 3
) (
	output logic sd_clk,
	output logic o_rst_n
);

	// Free-running clock, starts low
	initial
	begin
		sd_clk = 1'b0;
		forever
			#(PERIOD_NS / 2) sd_clk = ~sd_clk;
	end

	// Synchronous reset held for a few edges
	initial
	begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sd_clk);
		o_rst_n <= 1'b1;
	end

endmodule

//--- testbench/sd_card_checker.sv
/*
 Handshake and status assertions, bound into the card top level.
 Needs a simulator run with assertions enabled.
*/
`timescale 1ns/1ns
module sd_card_checker import sd_card_pkg::*; (
	input logic                   sd_clk,
	input logic                   i_rst_n,
	input logic                   i_reply_ready,
	input logic                   i_tx_ready,
	input logic                   o_reply_valid,
	input logic [CMD_IDX_W-1:0]   o_reply_idx,
	input logic                   o_reply_long,
	input logic [REPLY_ARG_W-1:0] o_reply_arg,
	input logic                   o_tx_valid,
	input logic [SD_WORD_W-1:0]   o_tx_data,
	input logic                   o_tx_last,
	input logic                   o_card_busy
);

	// Number of failed assertions so far
	int unsigned fail_count = 0;

	// Pending reply stays put until the host takes it
	reply_hold: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		o_reply_valid && !i_reply_ready |=> o_reply_valid && $stable(o_reply_idx)
			&& $stable(o_reply_long) && $stable(o_reply_arg))
		else
		begin
			$error("Reply changed before it was accepted");
			fail_count++;
		end

	// Stalled stream word must not move
	tx_hold: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last))
		else
		begin
			$error("Transmit word changed during a stall");
			fail_count++;
		end

	// Streaming and write busy are separate engine states
	busy_excl: assert property (@(posedge sd_clk) disable iff (!i_rst_n)
		!(o_tx_valid && o_card_busy))
		else
		begin
			$error("Transmit valid and card busy high together");
			fail_count++;
		end

	// Control outputs quiet right after reset
	reset_quiet: assert property (@(posedge sd_clk)
		$rose(i_rst_n) |-> !o_reply_valid && !o_tx_valid && !o_tx_last && !o_card_busy)
		else
		begin
			$error("Control output high after reset");
			fail_count++;
		end

endmodule

bind sd_card_top sd_card_checker sd_card_checker_inst (.*);

//--- testbench/sd_card_tb.sv
/*
 Directed tests for the SD card model with default top parameters.
 Inputs change on rising edges, outputs are sampled on falling edges.
 The expected-data model assumes 16 blocks in the store.
*/
`timescale 1ns/1ns
module sd_card_tb import sd_card_pkg::*; ();

	localparam logic [15:0]      TB_RCA     = 16'h5a3c;
	localparam int               MEM_BLOCKS = 16;
	localparam int               WAIT_LIMIT = 4 * BLOCK_WORDS;
	localparam logic [5:0]       R3_IDX     = 6'h3f;
	localparam logic [31:0]      R1_IDLE    = 32'h100;
	localparam logic [31:0]      R1_APP     = R1_IDLE | (32'h1 << R1_APP_BIT);
	// CID assembled from its fields
	localparam logic [REPLY_ARG_W-1:0] EXP_CID = {8'h47, "GT", "MODEL", 8'h10,
		32'h1234_5678, 4'h0, 12'h1a5};

	logic                   sd_clk;
	logic                   i_rst_n;
	logic                   i_cmd_valid;
	logic [CMD_IDX_W-1:0]   i_cmd_idx;
	logic [SD_WORD_W-1:0]   i_cmd_arg;
	logic                   i_reply_ready;
	logic                   i_rx_valid;
	logic [SD_WORD_W-1:0]   i_rx_data;
	logic                   i_tx_ready;
	logic                   o_reply_valid;
	logic [CMD_IDX_W-1:0]   o_reply_idx;
	logic                   o_reply_long;
	logic [REPLY_ARG_W-1:0] o_reply_arg;
	logic                   o_tx_valid;
	logic [SD_WORD_W-1:0]   o_tx_data;
	logic                   o_tx_last;
	logic                   o_card_busy;

	logic [31:0]            rng;
	// Expected store contents
	logic [SD_WORD_W-1:0]   blk_data [0:MEM_BLOCKS-1][0:BLOCK_WORDS-1];

	tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(3)) tb_clock_gen_inst (
		.sd_clk(sd_clk), .o_rst_n(i_rst_n)
	);

	sd_card_top sd_card_top_inst (.*);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("Mismatch at %0t: %s got %0h expected %0h",
				$time, name, got, exp));
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (i_rst_n !== 1'b1)
		begin
			@(posedge sd_clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_error("Reset was never released");
		end
		@(posedge sd_clk);
	endtask

	//////////////////////////////////////////////////
	// Command channel helpers
	task automatic send_cmd(input logic [CMD_IDX_W-1:0] idx, input logic [31:0] arg);
		@(posedge sd_clk);
		i_cmd_valid <= 1'b1;
		i_cmd_idx   <= idx;
		i_cmd_arg   <= arg;
		@(posedge sd_clk);
		i_cmd_valid <= 1'b0;
	endtask

	// Reply due one cycle after the command
	task automatic expect_reply(input logic [CMD_IDX_W-1:0] idx, input logic long_rsp,
		input logic [REPLY_ARG_W-1:0] arg);
		@(negedge sd_clk);
		check_value("o_reply_valid", o_reply_valid, 1'b1);
		check_value("o_reply_idx", o_reply_idx, idx);
		check_value("o_reply_long", o_reply_long, long_rsp);
		check_value("o_reply_arg", o_reply_arg, arg);
		// One cycle of back-pressure, then accept
		@(posedge sd_clk);
		i_reply_ready <= 1'b1;
		@(posedge sd_clk);
		i_reply_ready <= 1'b0;
	endtask

	task automatic expect_no_reply();
		@(negedge sd_clk);
		check_value("o_reply_valid", o_reply_valid, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Block transfers
	task automatic write_block(input int blk);
		int cycles;
		int busy_len;
		send_cmd(CMD_WRITE_SINGLE, 32'(blk));
		expect_reply(CMD_WRITE_SINGLE, 1'b0, R1_IDLE);
		for (int i = 0; i < BLOCK_WORDS; i++)
		begin
			rng = lcg_step(rng);
			blk_data[blk][i] = rng;
			@(posedge sd_clk);
			i_rx_valid <= 1'b1;
			i_rx_data  <= rng;
		end
		@(posedge sd_clk);
		i_rx_valid <= 1'b0;
		// Busy should already be up one cycle after the last word
		cycles = 0;
		@(negedge sd_clk);
		while (!o_card_busy)
		begin
			cycles++;
			if (cycles > WAIT_LIMIT)
				stop_on_error("Card busy never rose after a write block");
			@(negedge sd_clk);
		end
		check_value("o_card_busy rise delay", cycles, 0);
		busy_len = 0;
		while (o_card_busy)
		begin
			busy_len++;
			if (busy_len > WAIT_LIMIT)
				stop_on_error("Card busy never fell after a write block");
			@(negedge sd_clk);
		end
		check_value("o_card_busy length", busy_len, BLOCK_WORDS + 1);
	endtask

	task automatic read_block(input int blk, input bit stall);
		int n;
		int cycles;
		send_cmd(CMD_READ_SINGLE, 32'(blk));
		expect_reply(CMD_READ_SINGLE, 1'b0, R1_IDLE);
		n = 0;
		cycles = 0;
		while (n < BLOCK_WORDS)
		begin
			@(posedge sd_clk);
			rng = lcg_step(rng);
			i_tx_ready <= stall ? rng[31] : 1'b1;
			@(negedge sd_clk);
			// Word moves on the next rising edge
			if (o_tx_valid && i_tx_ready)
			begin
				check_value("o_tx_data", o_tx_data, blk_data[blk][n]);
				check_value("o_tx_last", o_tx_last, n == BLOCK_WORDS - 1);
				n++;
				cycles = 0;
			end
			else
			begin
				cycles++;
				if (cycles > WAIT_LIMIT)
					stop_on_error("Read stream stopped before the block ended");
			end
		end
		@(posedge sd_clk);
		i_tx_ready <= 1'b0;
		// Stream ends once the last word is taken
		@(negedge sd_clk);
		check_value("o_tx_valid", o_tx_valid, 1'b0);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic voltage_mismatch_test();
		send_cmd(CMD_GO_IDLE, 32'h0);
		expect_no_reply();
		// Empty window keeps the card busy on every poll
		for (int i = 0; i < 3; i++)
		begin
			send_cmd(CMD_APP, 32'h0);
			expect_reply(CMD_APP, 1'b0, R1_APP);
			send_cmd(ACMD_SEND_OP_COND, 32'h0);
			expect_reply(R3_IDX, 1'b0, {8'h00, OCR_WINDOW, 8'h00});
		end
	endtask

	task automatic identification_test();
		send_cmd(CMD_GO_IDLE, 32'h0);
		expect_no_reply();
		send_cmd(CMD_SEND_IF_COND, 32'h1aa);
		expect_reply(CMD_SEND_IF_COND, 1'b0, 32'h1aa);
		// First poll still busy, second reports ready and high capacity
		send_cmd(CMD_APP, 32'h0);
		expect_reply(CMD_APP, 1'b0, R1_APP);
		send_cmd(ACMD_SEND_OP_COND, 32'h40ff_8000);
		expect_reply(R3_IDX, 1'b0, {2'b01, 6'h00, OCR_WINDOW, 8'h00});
		send_cmd(CMD_APP, 32'h0);
		expect_reply(CMD_APP, 1'b0, R1_APP);
		send_cmd(ACMD_SEND_OP_COND, 32'h40ff_8000);
		expect_reply(R3_IDX, 1'b0, {2'b11, 6'h00, OCR_WINDOW, 8'h00});
		send_cmd(CMD_ALL_SEND_CID, 32'h0);
		expect_reply(R3_IDX, 1'b1, EXP_CID);
		send_cmd(CMD_SEND_RCA, 32'h0);
		expect_reply(CMD_SEND_RCA, 1'b0, {TB_RCA, 16'h0});
	endtask

	task automatic selection_test();
		// Not selected yet, so no read is taken
		send_cmd(CMD_READ_SINGLE, 32'h0);
		expect_no_reply();
		send_cmd(CMD_SELECT, 32'h1234_0000);
		expect_no_reply();
		send_cmd(CMD_SELECT, {TB_RCA, 16'h0});
		expect_reply(CMD_SELECT, 1'b0, R1_IDLE);
	endtask

	task automatic write_read_test();
		write_block(3);
		read_block(3, 1'b0);
	endtask

	task automatic backpressure_test();
		write_block(5);
		read_block(3, 1'b1);
		read_block(5, 1'b1);
	endtask

	initial
	begin
		i_cmd_valid   = 1'b0;
		i_cmd_idx     = '0;
		i_cmd_arg     = '0;
		i_reply_ready = 1'b0;
		i_rx_valid    = 1'b0;
		i_rx_data     = '0;
		i_tx_ready    = 1'b0;
		rng           = 32'hb75c_9363;
		wait_reset_release();
		voltage_mismatch_test();
		identification_test();
		selection_test();
		write_read_test();
		backpressure_test();
		if (sd_card_top_inst.sd_card_checker_inst.fail_count != 0)
			stop_on_error("Bound checker assertions failed during the run");
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

//--- sources.f
design/sd_card_pkg.sv
design/sd_word_ram.sv
design/sd_cmd_fsm.sv
design/sd_data_engine.sv
design/sd_card_top.sv
testbench/tb_clock_gen.sv
testbench/sd_card_checker.sv
testbench/sd_card_tb.sv

//--- Makefile
# Verilator flow for the SD card model
VERILATOR  ?= verilator
TOP        ?= sd_card_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
